// File: hdl/sdram_tg_defines.svh
`ifndef SDRAM_TG_DEFINES_SVH
`define SDRAM_TG_DEFINES_SVH

// --------------------
// Bus and pin widths
// --------------------
`define SDRAM_DW    16
`define SDRAM_AW    13
`define SDRAM_COLW  9
`define SDRAM_BAW   2
`define WB_AW       24

// Words covered by one traffic sweep
`define TG_WORDS    64

// --------------------
// SDRAM timing in clock cycles
// --------------------
// Power-up wait, shortened for simulation
`define T_INIT      100
// ACTIVE to READ/WRITE
`define T_RCD       2
// Precharge recovery, also used after mode load
`define T_RP        2
// Auto-refresh recovery
`define T_RFC       7
// Longest allowed gap between refreshes
`define T_REFI      390
`define CAS_LAT     2

`endif

// File: hdl/sdram_tg_pkg.sv
`include "sdram_tg_defines.svh"

package sdram_tg_pkg;

    // Command encoding is {ras_n, cas_n, we_n}
    typedef enum logic [2:0] {
        CMD_LOAD_MODE = 3'b000,
        CMD_REFRESH   = 3'b001,
        CMD_PRECHARGE = 3'b010,
        CMD_ACTIVE    = 3'b011,
        CMD_WRITE     = 3'b100,
        CMD_READ      = 3'b101,
        CMD_NOP       = 3'b111
    } sdram_cmd_e;

    // Command and address pins towards the memory
    typedef struct packed {
        logic                  cke;
        sdram_cmd_e            cmd;
        logic [`SDRAM_BAW-1:0] ba;
        logic [`SDRAM_AW-1:0]  a;
        logic [1:0]            dqm;
    } sdram_pins_t;

    // --------------------
    // Wishbone style bus
    // --------------------
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_AW-1:0]    adr;
        logic [`SDRAM_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic                 stall;
        logic [`SDRAM_DW-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRECHARGE,
        INIT_REFRESH,
        INIT_MODE,
        IDLE,
        REFRESH,
        ACTIVATE,
        ACCESS,
        READ_WAIT,
        RECOVER
    } ctrl_state_e;

    typedef enum logic [1:0] {
        TG_IDLE,
        TG_WRITE,
        TG_READ,
        TG_NEXT
    } tg_state_e;

endpackage

// File: hdl/sdram_ctrl.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module sdram_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  sdram_tg_pkg::wb_req_t    bus_req,
    output sdram_tg_pkg::wb_rsp_t    bus_rsp,
    output sdram_tg_pkg::sdram_pins_t sdram_pins,
    output logic                     sdram_clk,
    output logic [`SDRAM_DW-1:0]     sdram_wdata,
    output logic                     sdram_wdata_en,
    input  logic [`SDRAM_DW-1:0]     sdram_rdata
);
    import sdram_tg_pkg::*;

    localparam int AW      = `SDRAM_AW;
    localparam int WAIT_W  = $clog2(`T_INIT + 1);
    localparam int REFI_W  = $clog2(`T_REFI + 1);
    localparam int CAS_W   = $clog2(`CAS_LAT + 1);
    localparam int COL_LSB = `SDRAM_BAW;
    localparam int ROW_LSB = `SDRAM_BAW + `SDRAM_COLW;

    // Single location writes, CAS latency, sequential, burst length 1
    localparam logic [AW-1:0] MODE_REG =
        AW'({3'b000, 1'b1, 2'b00, 3'(`CAS_LAT), 1'b0, 3'b000});

    ctrl_state_e             state;
    logic [WAIT_W-1:0]       wait_cnt;
    logic                    wait_done;
    logic [REFI_W-1:0]       refi_cnt;
    logic                    ref_pending;
    logic                    ref_issue;
    logic [CAS_W-1:0]        cas_cnt;
    logic                    rd_capture;
    logic                    init_ref_last;
    sdram_pins_t             pins_q;
    logic                    ack_q;
    logic                    wdata_en_q;
    logic                    stall;
    logic                    accept;

    logic                    req_we_q;
    logic [`SDRAM_COLW-1:0]  req_col_q;
    logic [`SDRAM_DW-1:0]    wdat_q;
    logic [`SDRAM_DW-1:0]    rdat_q;

    assign wait_done  = (wait_cnt == '0);
    assign ref_issue  = (state == IDLE) && ref_pending;
    assign rd_capture = (state == READ_WAIT) && (cas_cnt == '0);

    // Only an idle controller with no refresh due takes a request
    assign stall  = !((state == IDLE) && !ref_pending);
    assign accept = bus_req.cyc && bus_req.stb && !stall;

    // --------------------
    // Refresh interval
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refi_cnt    <= REFI_W'(`T_REFI - 1);
            ref_pending <= 1'b0;
        end else if (refi_cnt == '0) begin
            refi_cnt    <= REFI_W'(`T_REFI - 1);
            ref_pending <= 1'b1;
        end else begin
            refi_cnt <= refi_cnt - 1'b1;
            if (ref_issue) begin
                ref_pending <= 1'b0;
            end
        end
    end

    // --------------------
    // Command sequencer
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= INIT_WAIT;
            wait_cnt      <= WAIT_W'(`T_INIT - 1);
            cas_cnt       <= '0;
            init_ref_last <= 1'b0;
            pins_q        <= '{cke: 1'b0, cmd: CMD_NOP, ba: '0, a: '0, dqm: 2'b11};
            ack_q         <= 1'b0;
            wdata_en_q    <= 1'b0;
        end else begin
            // Commands and strobes last one cycle
            pins_q.cke <= 1'b1;
            pins_q.cmd <= CMD_NOP;
            ack_q      <= 1'b0;
            wdata_en_q <= 1'b0;
            if (!wait_done) begin
                wait_cnt <= wait_cnt - 1'b1;
            end

            case (state)
                INIT_WAIT: if (wait_done) begin
                    // Precharge all banks
                    pins_q.cmd   <= CMD_PRECHARGE;
                    pins_q.a[10] <= 1'b1;
                    wait_cnt     <= WAIT_W'(`T_RP - 1);
                    state        <= INIT_PRECHARGE;
                end
                INIT_PRECHARGE: if (wait_done) begin
                    pins_q.cmd <= CMD_REFRESH;
                    wait_cnt   <= WAIT_W'(`T_RFC - 1);
                    state      <= INIT_REFRESH;
                end
                INIT_REFRESH: if (wait_done) begin
                    if (!init_ref_last) begin
                        pins_q.cmd    <= CMD_REFRESH;
                        init_ref_last <= 1'b1;
                        wait_cnt      <= WAIT_W'(`T_RFC - 1);
                    end else begin
                        pins_q.cmd <= CMD_LOAD_MODE;
                        pins_q.ba  <= '0;
                        pins_q.a   <= MODE_REG;
                        wait_cnt   <= WAIT_W'(`T_RP - 1);
                        state      <= INIT_MODE;
                    end
                end
                INIT_MODE: if (wait_done) begin
                    pins_q.dqm <= 2'b00;
                    state      <= IDLE;
                end
                IDLE: begin
                    if (ref_issue) begin
                        pins_q.cmd <= CMD_REFRESH;
                        wait_cnt   <= WAIT_W'(`T_RFC - 1);
                        state      <= REFRESH;
                    end else if (accept) begin
                        // Open the row addressed by the request
                        pins_q.cmd <= CMD_ACTIVE;
                        pins_q.ba  <= bus_req.adr[`SDRAM_BAW-1:0];
                        pins_q.a   <= bus_req.adr[ROW_LSB +: `SDRAM_AW];
                        wait_cnt   <= WAIT_W'(`T_RCD - 1);
                        state      <= ACTIVATE;
                    end
                end
                REFRESH: if (wait_done) begin
                    state <= IDLE;
                end
                ACTIVATE: if (wait_done) begin
                    // Column access with A10 set for auto-precharge
                    pins_q.cmd <= req_we_q ? CMD_WRITE : CMD_READ;
                    pins_q.a   <= AW'({1'b1, 1'b0, req_col_q});
                    wdata_en_q <= req_we_q;
                    state      <= ACCESS;
                end
                ACCESS: begin
                    if (req_we_q) begin
                        ack_q    <= 1'b1;
                        wait_cnt <= WAIT_W'(`T_RP - 1);
                        state    <= RECOVER;
                    end else begin
                        cas_cnt <= CAS_W'(`CAS_LAT - 1);
                        state   <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (rd_capture) begin
                        ack_q    <= 1'b1;
                        wait_cnt <= WAIT_W'(`T_RP - 1);
                        state    <= RECOVER;
                    end else begin
                        cas_cnt <= cas_cnt - 1'b1;
                    end
                end
                RECOVER: if (wait_done) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            req_we_q  <= bus_req.we;
            req_col_q <= bus_req.adr[COL_LSB +: `SDRAM_COLW];
            wdat_q    <= bus_req.dat;
        end
        if (rd_capture) begin
            rdat_q <= sdram_rdata;
        end
    end

    always_comb begin
        bus_rsp.ack   = ack_q;
        bus_rsp.stall = stall;
        bus_rsp.dat   = rdat_q;
    end

    // Memory runs on the controller clock
    assign sdram_clk      = clk;
    assign sdram_pins     = pins_q;
    assign sdram_wdata    = wdat_q;
    assign sdram_wdata_en = wdata_en_q;

endmodule

// File: hdl/wbm_traffic_gen.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module wbm_traffic_gen (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    output sdram_tg_pkg::wb_req_t bus_req,
    input  sdram_tg_pkg::wb_rsp_t bus_rsp,
    output logic                  data_mismatch,
    output logic [7:0]            sweep_count
);
    import sdram_tg_pkg::*;

    localparam int ADDR_W = $clog2(`TG_WORDS);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`TG_WORDS - 1);

    tg_state_e            state;
    logic [ADDR_W-1:0]    addr_cnt;
    logic [7:0]           addr_byte;
    logic [`SDRAM_DW-1:0] pattern;
    logic                 last_word;

    // Address in the high byte, its inverse low, both XORed with the sweep
    assign addr_byte = 8'(addr_cnt);
    assign pattern   = {addr_byte, ~addr_byte} ^ {sweep_count, sweep_count};
    assign last_word = (addr_cnt == LAST_ADDR);

    // --------------------
    // Sweep sequencer
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= TG_IDLE;
            addr_cnt      <= '0;
            sweep_count   <= '0;
            data_mismatch <= 1'b0;
        end else begin
            case (state)
                TG_IDLE: begin
                    addr_cnt <= '0;
                    if (enable) begin
                        state <= TG_WRITE;
                    end
                end
                TG_WRITE: if (bus_rsp.ack) begin
                    addr_cnt <= last_word ? '0 : addr_cnt + 1'b1;
                    if (!enable) begin
                        state <= TG_IDLE;
                    end else if (last_word) begin
                        state <= TG_READ;
                    end
                end
                TG_READ: if (bus_rsp.ack) begin
                    // Sticky until reset
                    if (bus_rsp.dat != pattern) begin
                        data_mismatch <= 1'b1;
                    end
                    addr_cnt <= last_word ? '0 : addr_cnt + 1'b1;
                    if (last_word) begin
                        state <= TG_NEXT;
                    end else if (!enable) begin
                        state <= TG_IDLE;
                    end
                end
                TG_NEXT: begin
                    sweep_count <= sweep_count + 1'b1;
                    addr_cnt    <= '0;
                    state       <= enable ? TG_WRITE : TG_IDLE;
                end
                default: state <= TG_IDLE;
            endcase
        end
    end

    // One request held open per access until ack
    always_comb begin
        bus_req.cyc = (state == TG_WRITE) || (state == TG_READ);
        bus_req.stb = bus_req.cyc;
        bus_req.we  = (state == TG_WRITE);
        bus_req.adr = `WB_AW'(addr_cnt);
        bus_req.dat = pattern;
    end

endmodule

// File: hdl/sdram_tg_top.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module sdram_tg_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      enable,
    output logic                      data_mismatch,
    output logic [7:0]                sweep_count,
    output sdram_tg_pkg::sdram_pins_t sdram_pins,
    output logic                      sdram_clk,
    output logic [`SDRAM_DW-1:0]      sdram_wdata,
    output logic                      sdram_wdata_en,
    input  logic [`SDRAM_DW-1:0]      sdram_rdata
);
    import sdram_tg_pkg::*;

    // Memory access bus between generator and controller
    wb_req_t tg_req;
    wb_rsp_t ctrl_rsp;

    wbm_traffic_gen u_traffic_gen (
        .clk           (clk          ),
        .arst_n        (arst_n       ),
        .enable        (enable       ),
        .bus_req       (tg_req       ),
        .bus_rsp       (ctrl_rsp     ),
        .data_mismatch (data_mismatch),
        .sweep_count   (sweep_count  )
    );

    sdram_ctrl u_sdram_ctrl (
        .clk            (clk           ),
        .arst_n         (arst_n        ),
        .bus_req        (tg_req        ),
        .bus_rsp        (ctrl_rsp      ),
        .sdram_pins     (sdram_pins    ),
        .sdram_clk      (sdram_clk     ),
        .sdram_wdata    (sdram_wdata   ),
        .sdram_wdata_en (sdram_wdata_en),
        .sdram_rdata    (sdram_rdata   )
    );

endmodule

// File: verif/sdram_model.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module sdram_model (
    input  logic                      clk,
    input  sdram_tg_pkg::sdram_pins_t pins,
    input  logic [`SDRAM_DW-1:0]      wdata,
    input  logic                      wdata_en,
    output logic [`SDRAM_DW-1:0]      rdata,
    input  logic                      fault_en,
    input  logic [`WB_AW-1:0]         fault_addr
);
    import sdram_tg_pkg::*;

    localparam int IDX_W = `SDRAM_COLW + `SDRAM_BAW;
    localparam int DEPTH = 1 << IDX_W;

    // Words are stored by {column, bank}, all rows share them
    logic [`SDRAM_DW-1:0] mem [DEPTH];
    logic [`SDRAM_AW-1:0] open_row [1 << `SDRAM_BAW];
    logic [`SDRAM_DW-1:0] rd_pipe [`CAS_LAT];
    logic [IDX_W-1:0]     word_idx;
    logic [`WB_AW-1:0]    full_addr;
    logic                 fault_hit;

    assign word_idx  = {pins.a[`SDRAM_COLW-1:0], pins.ba};
    assign full_addr = {open_row[pins.ba], word_idx};
    assign fault_hit = fault_en && (full_addr == fault_addr);
    assign rdata     = rd_pipe[`CAS_LAT-1];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'(i) ^ 16'h5a3c;
        end
        for (int b = 0; b < (1 << `SDRAM_BAW); b++) begin
            open_row[b] = '0;
        end
        for (int i = 0; i < `CAS_LAT; i++) begin
            rd_pipe[i] = '0;
        end
    end

    // --------------------
    // Command decode
    // --------------------
    always @(posedge clk) begin
        // Read data walks the CAS latency pipe
        for (int i = `CAS_LAT - 1; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= '0;
        if (pins.cke) begin
            case (pins.cmd)
                CMD_ACTIVE: open_row[pins.ba] <= pins.a;
                CMD_WRITE: begin
                    if (wdata_en) begin
                        mem[word_idx] <= wdata;
                    end
                end
                CMD_READ: begin
                    // Injected fault flips bit 0 on the way out
                    rd_pipe[0] <= mem[word_idx] ^ {{(`SDRAM_DW-1){1'b0}}, fault_hit};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: verif/sdram_tg_asserts.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module sdram_tg_asserts (
    input logic                      clk,
    input logic                      arst_n,
    input sdram_tg_pkg::sdram_pins_t sdram_pins,
    input sdram_tg_pkg::wb_rsp_t     bus_rsp,
    input logic                      sdram_wdata_en,
    input sdram_tg_pkg::ctrl_state_e state
);
    import sdram_tg_pkg::*;

    // Slack for an access still running when the interval ends
    localparam logic [9:0] REF_LIMIT = 10'(`T_REFI + 32);

    logic       ref_armed;
    logic [9:0] ref_gap;

    // Property failures over the whole run
    int         fail_count;

    initial fail_count = 0;

    // Cycles since the last REFRESH, saturating
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ref_armed <= 1'b0;
            ref_gap   <= '0;
        end else begin
            if (state == IDLE) begin
                ref_armed <= 1'b1;
            end
            if (sdram_pins.cmd == CMD_REFRESH) begin
                ref_gap <= '0;
            end else if (ref_gap != '1) begin
                ref_gap <= ref_gap + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        (sdram_pins.cmd == CMD_READ || sdram_pins.cmd == CMD_WRITE)
        |-> $past(sdram_pins.cmd, `T_RCD) == CMD_ACTIVE)
    else begin
        fail_count++;
        $error("column command without ACTIVE %0d cycles before", `T_RCD);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.ack |=> !bus_rsp.ack)
    else begin
        fail_count++;
        $error("ack held high for two cycles");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        ref_armed |-> ref_gap <= REF_LIMIT)
    else begin
        fail_count++;
        $error("refresh interval exceeded, gap %0d cycles", ref_gap);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        sdram_wdata_en |-> sdram_pins.cmd == CMD_WRITE)
    else begin
        fail_count++;
        $error("write data enable outside a WRITE command");
    end

endmodule

bind sdram_ctrl sdram_tg_asserts u_ctrl_asserts (
    .clk            (clk           ),
    .arst_n         (arst_n        ),
    .sdram_pins     (sdram_pins    ),
    .bus_rsp        (bus_rsp       ),
    .sdram_wdata_en (sdram_wdata_en),
    .state          (state         )
);

// File: verif/tb_sdram_tg.sv
`timescale 1ns/1ps
`include "sdram_tg_defines.svh"

module tb_sdram_tg;
    import sdram_tg_pkg::*;

    localparam int NUM_ROWS      = 6;
    localparam int SWEEP_TIMEOUT = 4000;

    typedef struct packed {
        logic              fault_en;
        logic [`WB_AW-1:0] fault_addr;
        logic [7:0]        sweeps;
        logic              exp_mismatch;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 enable;
    logic                 fault_en;
    logic [`WB_AW-1:0]    fault_addr;
    logic                 data_mismatch;
    logic [7:0]           sweep_count;
    sdram_pins_t          sdram_pins;
    logic                 sdram_clk;
    logic [`SDRAM_DW-1:0] sdram_wdata;
    logic                 sdram_wdata_en;
    logic [`SDRAM_DW-1:0] sdram_rdata;

    row_t        rows [NUM_ROWS];
    logic [31:0] rng_state;
    logic [`WB_AW-1:0] rnd_addr;
    logic        run_ok;
    int          checks;
    int          errors;
    int          timeouts;
    int          assert_fails;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    sdram_tg_top dut (
        .clk            (clk           ),
        .arst_n         (arst_n        ),
        .enable         (enable        ),
        .data_mismatch  (data_mismatch ),
        .sweep_count    (sweep_count   ),
        .sdram_pins     (sdram_pins    ),
        .sdram_clk      (sdram_clk     ),
        .sdram_wdata    (sdram_wdata   ),
        .sdram_wdata_en (sdram_wdata_en),
        .sdram_rdata    (sdram_rdata   )
    );

    sdram_model u_mem (
        .clk        (sdram_clk     ),
        .pins       (sdram_pins    ),
        .wdata      (sdram_wdata   ),
        .wdata_en   (sdram_wdata_en),
        .rdata      (sdram_rdata   ),
        .fault_en   (fault_en      ),
        .fault_addr (fault_addr    )
    );

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %0b, expected %0b", $time, what, got, want);
        end
    endtask

    task automatic check_count(input logic [7:0] got, input logic [7:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] want, input int addr);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t ns: memory word %0d is %h, expected %h", $time, addr, got, want);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        enable = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    // Address byte high, its inverse low, both XORed with the sweep number
    task automatic verify_pattern(input logic [7:0] sweep);
        logic [7:0]  a8;
        logic [15:0] want;
        for (int a = 0; a < `TG_WORDS; a++) begin
            a8   = 8'(a);
            want = {a8 ^ sweep, ~a8 ^ sweep};
            check_word(u_mem.mem[a], want, a);
        end
    endtask

    // Memory and flag are checked each time a sweep completes
    task automatic run_sweeps(input row_t row, output logic ok);
        int         idle_cycles;
        logic [7:0] last_count;
        ok          = 1'b1;
        idle_cycles = 0;
        last_count  = sweep_count;
        while (ok && sweep_count != row.sweeps) begin
            @(posedge clk);
            #1;
            if (sweep_count != last_count) begin
                last_count  = sweep_count;
                idle_cycles = 0;
                check_flag(data_mismatch, row.exp_mismatch, "data_mismatch after sweep");
                verify_pattern(sweep_count - 8'd1);
            end else begin
                idle_cycles++;
                if (idle_cycles > SWEEP_TIMEOUT) begin
                    $display("Timeout: sweep_count stuck at %0d, target %0d",
                             sweep_count, row.sweeps);
                    timeouts++;
                    ok = 1'b0;
                end
            end
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        enable       = 1'b0;
        fault_en     = 1'b0;
        fault_addr   = '0;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        assert_fails = 0;
        run_ok       = 1'b1;
        rng_state    = 32'd96;

        // fault_en, fault_addr, sweeps, expected data_mismatch
        rows[0] = '{1'b0, 24'd7,   8'd2, 1'b0};
        rows[1] = '{1'b1, 24'd5,   8'd3, 1'b1};
        rows[2] = '{1'b1, 24'd63,  8'd2, 1'b1};
        rows[3] = '{1'b1, 24'd200, 8'd1, 1'b0};
        rng_state = xorshift32(rng_state);
        rnd_addr  = {18'h0, rng_state[5:0]};
        rows[4] = '{1'b1, rnd_addr, 8'd2, rnd_addr < 24'(`TG_WORDS)};
        rng_state = xorshift32(rng_state);
        rnd_addr  = {16'h0, 2'b01, rng_state[5:0]};
        rows[5] = '{1'b1, rnd_addr, 8'd1, rnd_addr < 24'(`TG_WORDS)};

        for (int r = 0; r < NUM_ROWS && run_ok; r++) begin
            fault_en   = rows[r].fault_en;
            fault_addr = rows[r].fault_addr;
            apply_reset();
            check_flag(data_mismatch, 1'b0, "data_mismatch after reset");
            check_count(sweep_count, 8'd0, "sweep_count after reset");
            enable = 1'b1;
            run_sweeps(rows[r], run_ok);
        end

        // Enable low mid sweep must freeze the counter
        if (run_ok) begin
            fault_en = 1'b0;
            apply_reset();
            enable = 1'b1;
            run_sweeps('{1'b0, 24'd0, 8'd1, 1'b0}, run_ok);
            enable = 1'b0;
            repeat (1500) @(posedge clk);
            #1;
            check_count(sweep_count, 8'd1, "sweep_count with enable low");
        end

        assert_fails = dut.u_sdram_ctrl.u_ctrl_asserts.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sdram_tg.f
+incdir+hdl
hdl/sdram_tg_pkg.sv
hdl/sdram_ctrl.sv
hdl/wbm_traffic_gen.sv
hdl/sdram_tg_top.sv
verif/sdram_model.sv
verif/sdram_tg_asserts.sv
verif/tb_sdram_tg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdram_tg
FILELIST  ?= sdram_tg.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
